// File: source/eth_defs.svh
`ifndef ETH_DEFS_SVH
`define ETH_DEFS_SVH

// idle cycles counted by the controller before each transmit
`define ETH_GAP      90

// payload bytes in every transmitted frame
`define ETH_TX_LEN   64

// preamble and delimiter
`define ETH_PRE_LEN  7
`define ETH_PRE_BYTE 8'h55
`define ETH_SFD      8'hD5

// buffer address widths, 8192 and 128 bytes
`define ETH_TX_AW    13
`define ETH_RX_AW    7

`endif

// File: source/eth_pkg.sv
`default_nettype none

package eth_pkg;

    // frame scheduling states of the controller
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        WAIT   = 3'd1,
        ETH_RX = 3'd2,
        ETH_TX = 3'd3,
        DONE   = 3'd4
    } eth_ctrl_state_t;

    typedef enum logic [2:0] {
        TX_IDLE = 3'd0,
        TX_PRE  = 3'd1,
        TX_SFD  = 3'd2,
        TX_DATA = 3'd3,
        TX_END  = 3'd4
    } eth_tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE = 2'd0,
        RX_PRE  = 2'd1,
        RX_DATA = 2'd2
    } eth_rx_state_t;

endpackage

`default_nettype wire

// File: source/eth_buf.sv
`timescale 1ns/1ps
`default_nettype none

module eth_buf #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 8
) (
    input  wire logic              clk,
    input  wire logic              wr_en,
    input  wire logic [ADDR_W-1:0] wr_addr,
    input  wire logic [DATA_W-1:0] wr_data,
    input  wire logic [ADDR_W-1:0] rd_addr,
    output logic      [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [0:(2**ADDR_W)-1];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read data appears one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: source/eth_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_defs.svh"

module eth_ctrl import eth_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic fs_rx,
    input  wire logic fd_tx,
    output logic      fs_tx
);

    eth_ctrl_state_t state;
    eth_ctrl_state_t state_nxt;
    logic [15:0]     gap_cnt;
    logic            gap_done;

    assign gap_done = (gap_cnt >= 16'(`ETH_GAP - 1));
    assign fs_tx    = (state == ETH_TX);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scheduling FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: state_nxt = WAIT;
            WAIT: begin
                // a receive in progress defers the transmit
                if (fs_rx) begin
                    state_nxt = ETH_RX;
                end else if (gap_done) begin
                    state_nxt = ETH_TX;
                end
            end
            ETH_RX: begin
                if (!fs_rx) begin
                    state_nxt = DONE;
                end
            end
            ETH_TX: begin
                if (fd_tx) begin
                    state_nxt = DONE;
                end
            end
            DONE:    state_nxt = WAIT;
            default: state_nxt = IDLE;
        endcase
    end

    // inter-frame gap, restarts on every return to WAIT
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gap_cnt <= '0;
        end else if (state == WAIT) begin
            gap_cnt <= gap_cnt + 16'd1;
        end else begin
            gap_cnt <= '0;
        end
    end

    // the framer only reports completion of a frame this block scheduled
    a_fd_in_tx: assert property (@(posedge clk) disable iff (rst)
        fd_tx |-> state == ETH_TX);

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {IDLE, WAIT, ETH_RX, ETH_TX, DONE});

endmodule

`default_nettype wire

// File: source/eth_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_defs.svh"

module eth_tx import eth_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  fs_tx,
    output logic                       fd_tx,
    output logic      [`ETH_TX_AW-1:0] tx_raddr,
    input  wire logic [7:0]            tx_rdata,
    output logic                       txen,
    output logic      [7:0]            txd
);

    eth_tx_state_t state;
    logic          fs_tx_d;
    logic          start;
    logic [7:0]    cnt;

    assign start = fs_tx & ~fs_tx_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // framer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // tx_raddr runs one byte ahead of txd, covering the buffer read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= TX_IDLE;
            fs_tx_d  <= 1'b0;
            cnt      <= '0;
            tx_raddr <= '0;
            txen     <= 1'b0;
            txd      <= '0;
            fd_tx    <= 1'b0;
        end else begin
            fs_tx_d <= fs_tx;
            fd_tx   <= 1'b0;
            case (state)
                TX_IDLE: begin
                    tx_raddr <= '0;
                    if (start) begin
                        state <= TX_PRE;
                        cnt   <= '0;
                        txen  <= 1'b1;
                        txd   <= `ETH_PRE_BYTE;
                    end
                end
                TX_PRE: begin
                    if (cnt == 8'(`ETH_PRE_LEN - 1)) begin
                        state    <= TX_SFD;
                        txd      <= `ETH_SFD;
                        tx_raddr <= tx_raddr + 1'b1;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                TX_SFD: begin
                    // first payload byte was fetched during the last preamble byte
                    state    <= TX_DATA;
                    cnt      <= '0;
                    txd      <= tx_rdata;
                    tx_raddr <= tx_raddr + 1'b1;
                end
                TX_DATA: begin
                    if (cnt == 8'(`ETH_TX_LEN - 1)) begin
                        state    <= TX_END;
                        txen     <= 1'b0;
                        txd      <= '0;
                        fd_tx    <= 1'b1;
                        tx_raddr <= '0;
                    end else begin
                        cnt      <= cnt + 8'd1;
                        txd      <= tx_rdata;
                        tx_raddr <= tx_raddr + 1'b1;
                    end
                end
                TX_END:  state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    // bytes go out only inside the slot the controller granted
    a_txen_in_slot: assert property (@(posedge clk) disable iff (rst)
        txen |-> fs_tx);

    a_fd_pulse: assert property (@(posedge clk) disable iff (rst)
        fd_tx |=> !fd_tx);

endmodule

`default_nettype wire

// File: source/eth_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_defs.svh"

module eth_rx import eth_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  rxdv,
    input  wire logic                  rxer,
    input  wire logic [7:0]            rxd,
    output logic                       fs_rx,
    output logic      [`ETH_RX_AW-1:0] rx_waddr,
    output logic      [7:0]            rx_wdata,
    output logic                       rx_we,
    output logic                       rx_done,
    output logic      [7:0]            rx_len,
    output logic                       rx_err
);

    eth_rx_state_t state;
    logic [7:0]    cnt;
    logic          err;

    // busy from the byte after the delimiter until rxdv drops
    assign fs_rx = (state == RX_DATA);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // deframer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            err      <= 1'b0;
            rx_waddr <= '0;
            rx_we    <= 1'b0;
            rx_done  <= 1'b0;
            rx_len   <= '0;
            rx_err   <= 1'b0;
        end else begin
            rx_we   <= 1'b0;
            rx_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    err <= rxdv & rxer;
                    if (rxdv) begin
                        if (rxd == `ETH_SFD) begin
                            state <= RX_DATA;
                        end else begin
                            state <= RX_PRE;
                        end
                    end
                end
                RX_PRE: begin
                    err <= err | (rxdv & rxer);
                    // cut off before the delimiter, drop without a report
                    if (!rxdv) begin
                        state <= RX_IDLE;
                    end else if (rxd == `ETH_SFD) begin
                        state <= RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (rxdv) begin
                        rx_we    <= 1'b1;
                        rx_waddr <= cnt[`ETH_RX_AW-1:0];
                        cnt      <= cnt + 8'd1;
                        err      <= err | rxer;
                    end else begin
                        rx_done <= 1'b1;
                        rx_len  <= cnt;
                        rx_err  <= err;
                        state   <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // write data lines up with rx_waddr
    always_ff @(posedge clk) begin
        rx_wdata <= rxd;
    end

    // writes belong to a frame, never to the idle line
    a_no_we_idle: assert property (@(posedge clk) disable iff (rst)
        state == RX_IDLE |-> !rx_we);

endmodule

`default_nettype wire

// File: source/eth_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_defs.svh"

module eth_top (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  tx_wr_en,
    input  wire logic [`ETH_TX_AW-1:0] tx_wr_addr,
    input  wire logic [7:0]            tx_wr_data,
    input  wire logic [`ETH_RX_AW-1:0] rx_rd_addr,
    output logic      [7:0]            rx_rd_data,
    input  wire logic                  rxdv,
    input  wire logic                  rxer,
    input  wire logic [7:0]            rxd,
    output logic                       txen,
    output logic      [7:0]            txd,
    output logic                       rx_done,
    output logic      [7:0]            rx_len,
    output logic                       rx_err
);

    logic                  fs_tx;
    logic                  fd_tx;
    logic                  fs_rx;
    logic [`ETH_TX_AW-1:0] tx_raddr;
    logic [7:0]            tx_rdata;
    logic [`ETH_RX_AW-1:0] rx_waddr;
    logic [7:0]            rx_wdata;
    logic                  rx_we;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control and framers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    eth_ctrl i_ctrl (
        .clk   (clk),
        .rst   (rst),
        .fs_rx (fs_rx),
        .fd_tx (fd_tx),
        .fs_tx (fs_tx)
    );

    eth_tx i_tx (
        .clk      (clk),
        .rst      (rst),
        .fs_tx    (fs_tx),
        .fd_tx    (fd_tx),
        .tx_raddr (tx_raddr),
        .tx_rdata (tx_rdata),
        .txen     (txen),
        .txd      (txd)
    );

    eth_rx i_rx (
        .clk      (clk),
        .rst      (rst),
        .rxdv     (rxdv),
        .rxer     (rxer),
        .rxd      (rxd),
        .fs_rx    (fs_rx),
        .rx_waddr (rx_waddr),
        .rx_wdata (rx_wdata),
        .rx_we    (rx_we),
        .rx_done  (rx_done),
        .rx_len   (rx_len),
        .rx_err   (rx_err)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // buffers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // host writes, framer reads
    eth_buf #(
        .ADDR_W (`ETH_TX_AW),
        .DATA_W (8)
    ) tx_buf (
        .clk     (clk),
        .wr_en   (tx_wr_en),
        .wr_addr (tx_wr_addr),
        .wr_data (tx_wr_data),
        .rd_addr (tx_raddr),
        .rd_data (tx_rdata)
    );

    // deframer writes, host reads
    eth_buf #(
        .ADDR_W (`ETH_RX_AW),
        .DATA_W (8)
    ) rx_buf (
        .clk     (clk),
        .wr_en   (rx_we),
        .wr_addr (rx_waddr),
        .wr_data (rx_wdata),
        .rd_addr (rx_rd_addr),
        .rd_data (rx_rd_data)
    );

endmodule

`default_nettype wire

// File: tb/tb_eth_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_defs.svh"

module tb_eth_top import eth_pkg::*; ();

    localparam int SEED      = 59003;
    localparam int N_TX      = 12;
    localparam int N_RX      = 24;
    localparam int MAX_RX    = 120;
    localparam int RX_DEPTH  = 2 ** `ETH_RX_AW;
    localparam int FRAME_LEN = `ETH_PRE_LEN + 1 + `ETH_TX_LEN;
    localparam int WDOG      = (N_TX + N_RX) * (`ETH_GAP + 80 + MAX_RX) * 4;

    logic                  clk;
    logic                  rst;
    logic                  tx_wr_en;
    logic [`ETH_TX_AW-1:0] tx_wr_addr;
    logic [7:0]            tx_wr_data;
    logic [`ETH_RX_AW-1:0] rx_rd_addr;
    logic [7:0]            rx_rd_data;
    logic                  rxdv;
    logic                  rxer;
    logic [7:0]            rxd;
    logic                  txen;
    logic [7:0]            txd;
    logic                  rx_done;
    logic [7:0]            rx_len;
    logic                  rx_err;

    logic [7:0] tx_model [0:`ETH_TX_LEN-1];
    logic [7:0] rx_model [0:RX_DEPTH-1];
    logic [7:0] exp_len_q [$];
    logic       exp_err_q [$];
    int         tx_idx;
    int         tx_frames;
    int         low_cnt;
    logic       hold_tx;

    eth_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .tx_wr_en   (tx_wr_en),
        .tx_wr_addr (tx_wr_addr),
        .tx_wr_data (tx_wr_data),
        .rx_rd_addr (rx_rd_addr),
        .rx_rd_data (rx_rd_data),
        .rxdv       (rxdv),
        .rxer       (rxer),
        .rxd        (rxd),
        .txen       (txen),
        .txd        (txd),
        .rx_done    (rx_done),
        .rx_len     (rx_len),
        .rx_err     (rx_err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reporting and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_failed(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_tx_byte(input logic [7:0] exp, input logic [7:0] got, input int idx);
        if (got !== exp) begin
            stop_failed($sformatf("error @ %0t: txd byte %0d is %h, expected %h",
                $time, idx, got, exp));
        end
    endtask

    task automatic check_rx_frame(input logic [7:0] exp_len, input logic exp_err,
                                  input logic [7:0] got_len, input logic got_err);
        if (got_len !== exp_len || got_err !== exp_err) begin
            stop_failed($sformatf("error @ %0t: rx frame len %0d err %b, expected len %0d err %b",
                $time, got_len, got_err, exp_len, exp_err));
        end
    endtask

    task automatic check_rx_byte(input int addr, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp) begin
            stop_failed($sformatf("error @ %0t: rx buffer[%0d] is %h, expected %h",
                $time, addr, got, exp));
        end
    endtask

    task automatic check_ctrl_state(input eth_ctrl_state_t exp, input eth_ctrl_state_t got);
        if (got !== exp) begin
            stop_failed($sformatf("error @ %0t: controller in %s, expected %s",
                $time, got.name(), exp.name()));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int rand_between(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    // preamble, delimiter, then the model payload
    function automatic logic [7:0] tx_frame_byte(input int idx);
        if (idx < `ETH_PRE_LEN) begin
            return `ETH_PRE_BYTE;
        end else if (idx == `ETH_PRE_LEN) begin
            return `ETH_SFD;
        end
        return tx_model[idx - `ETH_PRE_LEN - 1];
    endfunction

    task automatic wait_tx_rise();
        do @(posedge clk); while (!txen);
    endtask

    // returns on the first edge that samples txen low after a frame
    task automatic wait_tx_fall();
        wait_tx_rise();
        do @(posedge clk); while (txen);
    endtask

    task automatic fill_tx_buf();
        logic [7:0] b;
        for (int i = 0; i < `ETH_TX_LEN; i++) begin
            b = 8'($urandom);
            tx_model[i] = b;
            tx_wr_en   <= 1'b1;
            tx_wr_addr <= `ETH_TX_AW'(i);
            tx_wr_data <= b;
            @(posedge clk);
        end
        tx_wr_en <= 1'b0;
    endtask

    // cut frames stop after the preamble and expect no report
    task automatic send_frame(input int pre_len, input int pay_len, input int err_at,
                              input logic cut);
        logic [7:0] b;
        if (!cut) begin
            exp_len_q.push_back(8'(pay_len));
            exp_err_q.push_back(err_at >= 0);
        end
        for (int i = 0; i < pre_len; i++) begin
            rxdv <= 1'b1;
            rxd  <= `ETH_PRE_BYTE;
            @(posedge clk);
        end
        if (!cut) begin
            rxd <= `ETH_SFD;
            @(posedge clk);
            for (int i = 0; i < pay_len; i++) begin
                b = 8'($urandom);
                rx_model[i % RX_DEPTH] = b;
                rxd  <= b;
                rxer <= (i == err_at);
                @(posedge clk);
            end
        end
        rxdv <= 1'b0;
        rxer <= 1'b0;
        rxd  <= 8'h00;
    endtask

    task automatic read_rx_buf(input int n);
        for (int i = 0; i < n; i++) begin
            rx_rd_addr <= `ETH_RX_AW'(i);
            repeat (2) @(posedge clk);
            check_rx_byte(i, rx_model[i % RX_DEPTH], rx_rd_data);
        end
    endtask

    task automatic rewrite_loop();
        repeat (N_TX) begin
            wait_tx_fall();
            fill_tx_buf();
        end
    endtask

    task automatic rx_loop();
        int pre_len;
        int pay_len;
        int err_at;
        for (int i = 0; i < N_RX; i++) begin
            pre_len = rand_between(1, `ETH_PRE_LEN);
            pay_len = rand_between(1, MAX_RX);
            err_at  = -1;
            case (i % 6)
                0: repeat (rand_between(1, 40)) @(posedge clk);
                1: wait_tx_rise();
                2: begin
                    repeat (rand_between(1, 40)) @(posedge clk);
                    err_at = rand_between(0, pay_len - 1);
                end
                3: begin
                    send_frame(pre_len, 0, -1, 1'b1);
                    repeat (rand_between(2, 10)) @(posedge clk);
                end
                default: begin
                    // start late in the gap so the delimiter lands before it expires
                    wait_tx_fall();
                    repeat (rand_between(60, 80) - 1) @(posedge clk);
                    hold_tx = 1'b1;
                end
            endcase
            send_frame(pre_len, pay_len, err_at, 1'b0);
            if (hold_tx) begin
                @(posedge clk);
                check_ctrl_state(ETH_RX, i_dut.i_ctrl.state);
            end
            while (exp_len_q.size() != 0) @(posedge clk);
            hold_tx = 1'b0;
            read_rx_buf(pay_len);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        if (!rst) begin
            if (hold_tx && txen) begin
                stop_failed("a transmit started while a deferring frame was still received");
            end
            if (txen) begin
                if (tx_idx == 0 && tx_frames > 0 && low_cnt < `ETH_GAP + 2) begin
                    stop_failed($sformatf("txen was low for only %0d cycles between frames",
                        low_cnt));
                end
                if (tx_idx >= FRAME_LEN) begin
                    stop_failed("txen stayed high longer than one frame");
                end
                check_tx_byte(tx_frame_byte(tx_idx), txd, tx_idx);
                tx_idx  = tx_idx + 1;
                low_cnt = 0;
            end else begin
                if (tx_idx != 0) begin
                    if (tx_idx != FRAME_LEN) begin
                        stop_failed($sformatf("transmitted frame lasted %0d cycles", tx_idx));
                    end
                    tx_frames = tx_frames + 1;
                    tx_idx    = 0;
                end
                low_cnt = low_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && rx_done) begin
            if (exp_len_q.size() == 0) begin
                stop_failed("rx_done pulsed although no complete frame was sent");
            end else begin
                check_rx_frame(exp_len_q.pop_front(), exp_err_q.pop_front(), rx_len, rx_err);
            end
        end
    end

    initial begin
        repeat (WDOG) @(posedge clk);
        stop_failed($sformatf("timeout: the run did not finish within %0d clock cycles", WDOG));
    end

    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        hold_tx    = 1'b0;
        tx_wr_en   = 1'b0;
        tx_wr_addr = '0;
        tx_wr_data = '0;
        rx_rd_addr = '0;
        rxdv       = 1'b0;
        rxer       = 1'b0;
        rxd        = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        fill_tx_buf();
        fork
            rewrite_loop();
            rx_loop();
        join
        // one more frame so the last rewrite is seen on the line
        wait_tx_fall();
        @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+source
source/eth_pkg.sv
source/eth_buf.sv
source/eth_ctrl.sv
source/eth_tx.sv
source/eth_rx.sv
source/eth_top.sv
tb/tb_eth_top.sv
